//--- list.f
src/mul_pkg.sv
src/mul_issue_if.sv
src/operand_gather.sv
src/mul_pipeline.sv
src/mul_top.sv
verification/tb_mul_top.sv

//--- verification/mul_stimulus.txt
# ra rb blk1 blk2 tkt1 tkt2 dly1 dly2 rob_data1 rob_data2 fetch illegal flush gap
# All hex; dly counts cycles from when the request first appears
00000003 00000005 0 0 00 00 0 0 00000000 00000000 0 0 0 2
0000ffff 00010001 0 0 00 00 0 0 00000000 00000000 0 0 0 1
00012345 0000abcd 1 0 05 00 3 0 00000007 00000000 0 0 0 1
00000000 00000000 1 1 0a 0b 1 4 00000011 00000013 0 0 0 1
00000000 00000000 1 1 0c 0d 4 1 00000101 00000203 0 0 0 2
00000000 00000009 1 1 0e 0f 0 0 00000021 00000003 0 0 0 1
80000000 00000002 0 0 00 00 0 0 00000000 00000000 0 0 0 1
ffffffff ffffffff 0 0 00 00 0 0 00000000 00000000 0 0 0 1
00000100 00000000 0 1 00 12 0 2 00000000 10000000 0 0 0 1
00010000 00010000 0 0 00 00 0 0 00000000 00000000 0 0 0 1
00000004 00000006 1 1 13 14 2 3 00000005 00000007 1 0 0 1
00000004 00000006 1 0 15 00 0 0 00000009 00000000 0 1 0 2
00000008 0000000a 0 1 00 16 0 5 00000000 0000000b 1 1 0 2
00000002 00000003 0 0 00 00 0 0 00000000 00000000 0 0 0 0
00000007 00000008 0 0 00 00 0 0 00000000 00000000 0 0 0 0
00020000 00030000 0 0 00 00 0 0 00000000 00000000 0 0 0 0
12345678 00000010 0 0 00 00 0 0 00000000 00000000 0 0 0 2
00000011 00000022 0 0 00 00 0 0 00000000 00000000 0 0 0 0
00000033 00000044 0 0 00 00 0 0 00000000 00000000 0 0 0 0
00000055 00000066 0 0 00 00 0 0 00000000 00000000 0 0 1 2
00000000 00000019 1 0 20 00 1 0 00000017 00000000 0 0 0 0
00000006 00000007 0 0 00 00 0 0 00000000 00000000 0 0 0 1
00000000 00000000 1 1 21 22 2 2 0000c000 00040000 0 0 0 3

//--- verification/tb_mul_top.sv
`timescale 1ns/1ps

module tb_mul_top import mul_pkg::*;
();

    localparam int MUL_STAGES  = 3;
    localparam int STALL_LIMIT = 32;
    localparam int DRAIN_LIMIT = 40;
    localparam int MAX_TESTS   = 64;

    // One outstanding operation as writeback should report it
    typedef struct packed {
        logic [31:0] test_n;
        logic [31:0] due_edge;
        data_t       data;
        logic        ovf;
        logic        check_data;
        logic        fetch;
        logic        illegal;
        reg_addr_t   rd_addr;
        rob_id_t     instr_id;
        pc_t         pc;
    } expect_t;

    logic      clock;
    logic      rst_n;
    logic      flush;
    logic      req_valid;
    rob_id_t   req_instr_id;
    pc_t       req_pc;
    reg_addr_t req_rd_addr;
    data_t     req_ra_data;
    data_t     req_rb_data;
    rob_id_t   req_ticket_src1;
    rob_id_t   req_ticket_src2;
    logic      req_blocks_src1;
    logic      req_blocks_src2;
    logic      req_xcpt_fetch;
    logic      req_xcpt_illegal;
    logic      stall_decode;
    rob_id_t   rob_src1_id;
    rob_id_t   rob_src2_id;
    logic      rob_src1_hit;
    logic      rob_src2_hit;
    data_t     rob_src1_data;
    data_t     rob_src2_data;
    logic      wb_valid;
    rob_id_t   wb_instr_id;
    pc_t       wb_pc;
    reg_addr_t wb_rd_addr;
    data_t     wb_data;
    logic      wb_xcpt_fetch;
    logic      wb_xcpt_illegal;
    logic      wb_xcpt_overflow;

    // RoB model state
    logic      rob_hit1_en;
    logic      rob_hit2_en;
    rob_id_t   rob_tkt1;
    rob_id_t   rob_tkt2;

    // Fields of the current stimulus line
    logic [31:0] f_ra, f_rb, f_blk1, f_blk2, f_tkt1, f_tkt2, f_dly1, f_dly2;
    logic [31:0] f_robd1, f_robd2, f_fetch, f_ill, f_flush, f_gap;
    logic [8*256-1:0] line_buf;

    expect_t exp_q [$];
    int      test_errs [MAX_TESTS];
    int      error_count = 0;
    int      pass_count  = 0;
    int      fail_count  = 0;
    int      edge_count  = 0;
    logic    run_aborted = 1'b0;

    mul_top i_dut (
        .clock            (clock),
        .rst_n            (rst_n),
        .flush            (flush),
        .req_valid        (req_valid),
        .req_instr_id     (req_instr_id),
        .req_pc           (req_pc),
        .req_rd_addr      (req_rd_addr),
        .req_ra_data      (req_ra_data),
        .req_rb_data      (req_rb_data),
        .req_ticket_src1  (req_ticket_src1),
        .req_ticket_src2  (req_ticket_src2),
        .req_blocks_src1  (req_blocks_src1),
        .req_blocks_src2  (req_blocks_src2),
        .req_xcpt_fetch   (req_xcpt_fetch),
        .req_xcpt_illegal (req_xcpt_illegal),
        .stall_decode     (stall_decode),
        .rob_src1_id      (rob_src1_id),
        .rob_src2_id      (rob_src2_id),
        .rob_src1_hit     (rob_src1_hit),
        .rob_src2_hit     (rob_src2_hit),
        .rob_src1_data    (rob_src1_data),
        .rob_src2_data    (rob_src2_data),
        .wb_valid         (wb_valid),
        .wb_instr_id      (wb_instr_id),
        .wb_pc            (wb_pc),
        .wb_rd_addr       (wb_rd_addr),
        .wb_data          (wb_data),
        .wb_xcpt_fetch    (wb_xcpt_fetch),
        .wb_xcpt_illegal  (wb_xcpt_illegal),
        .wb_xcpt_overflow (wb_xcpt_overflow)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock)
    begin
        edge_count <= edge_count + 1;
    end

    // Combinational RoB that answers only for the ticket it was told about
    assign rob_src1_hit = rob_hit1_en && (rob_src1_id == rob_tkt1);
    assign rob_src2_hit = rob_hit2_en && (rob_src2_id == rob_tkt2);

    ////////////////////////////////////////////////////////////////////////////
    // Checking helpers

    task automatic compare_value(input string what, input logic [63:0] got,
                                 input logic [63:0] exp, input int test_n);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t: test %0d %s got %h expected %h",
                     $time, test_n, what, got, exp);
            error_count++;
            if (test_n >= 0)
                test_errs[test_n]++;
        end
    endtask

    task automatic finish_test(input int test_n, input string how);
        if (test_errs[test_n] == 0)
        begin
            pass_count++;
            $display("test %0d %s: ok", test_n, how);
        end
        else
        begin
            fail_count++;
            $display("test %0d %s: %0d errors", test_n, how, test_errs[test_n]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    // Idle cycles after a request with an optional flush in the first one
    task automatic idle_cycles(input int n, input logic do_flush);
        expect_t e;
        for (int i = 0; i < n; i++)
        begin
            @(negedge clock);
            req_valid   = 1'b0;
            rob_hit1_en = 1'b0;
            rob_hit2_en = 1'b0;
            flush       = do_flush && (i == 0);
            if (flush)
            begin
                // Everything in flight is lost on this edge
                while (exp_q.size() != 0)
                begin
                    e = exp_q.pop_front();
                    finish_test(e.test_n, "flushed");
                end
            end
        end
    endtask

    task automatic run_request(input int test_n);
        int       cycle;
        logic     seen1, seen2, hit1, hit2, xcpt, exp_stall, accepted;
        data_t    a;
        data_t    b;
        logic [63:0] prod;
        expect_t  e;
        @(negedge clock);
        flush            = 1'b0;
        req_valid        = 1'b1;
        req_instr_id     = rob_id_t'(test_n);
        req_pc           = pc_t'(32'h0000_1000 + 4 * test_n);
        req_rd_addr      = reg_addr_t'(test_n + 1);
        req_ra_data      = f_ra;
        req_rb_data      = f_rb;
        req_ticket_src1  = rob_id_t'(f_tkt1);
        req_ticket_src2  = rob_id_t'(f_tkt2);
        req_blocks_src1  = f_blk1[0];
        req_blocks_src2  = f_blk2[0];
        req_xcpt_fetch   = f_fetch[0];
        req_xcpt_illegal = f_ill[0];
        rob_tkt1         = rob_id_t'(f_tkt1);
        rob_tkt2         = rob_id_t'(f_tkt2);
        rob_src1_data    = f_robd1;
        rob_src2_data    = f_robd2;
        xcpt     = f_fetch[0] | f_ill[0];
        seen1    = 1'b0;
        seen2    = 1'b0;
        accepted = 1'b0;
        cycle    = 0;
        while (!accepted && !run_aborted)
        begin
            // Single-cycle hit pulse once the delay has elapsed
            hit1 = f_blk1[0] && (cycle == f_dly1);
            hit2 = f_blk2[0] && (cycle == f_dly2);
            rob_hit1_en = hit1;
            rob_hit2_en = hit2;
            #1;
            exp_stall = !xcpt && ((f_blk1[0] && !seen1 && !hit1) ||
                                  (f_blk2[0] && !seen2 && !hit2));
            compare_value("stall_decode", stall_decode, exp_stall, test_n);
            compare_value("rob_src1_id", rob_src1_id, rob_tkt1, test_n);
            compare_value("rob_src2_id", rob_src2_id, rob_tkt2, test_n);
            if (!exp_stall)
            begin
                accepted     = 1'b1;
                a            = f_blk1[0] ? f_robd1 : f_ra;
                b            = f_blk2[0] ? f_robd2 : f_rb;
                prod         = {32'b0, a} * {32'b0, b};
                e.test_n     = test_n;
                e.due_edge   = edge_count + MUL_STAGES + 1;
                e.data       = prod[31:0];
                e.ovf        = |prod[63:32];
                // Operand value is undefined when an exception skips the wait
                e.check_data = !((f_blk1[0] && !seen1 && !hit1) ||
                                 (f_blk2[0] && !seen2 && !hit2));
                e.fetch      = f_fetch[0];
                e.illegal    = f_ill[0];
                e.rd_addr    = req_rd_addr;
                e.instr_id   = req_instr_id;
                e.pc         = req_pc;
                exp_q.push_back(e);
            end
            else
            begin
                seen1 = seen1 | hit1;
                seen2 = seen2 | hit2;
                cycle++;
                if (cycle > STALL_LIMIT)
                begin
                    $display("Timeout: test %0d still stalled after %0d cycles",
                             test_n, STALL_LIMIT);
                    run_aborted = 1'b1;
                end
                else
                begin
                    @(negedge clock);
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Writeback monitor

    initial
    begin : wb_monitor
        expect_t e;
        forever
        begin
            @(posedge clock);
            #1;
            if (rst_n && wb_valid)
            begin
                if (exp_q.size() == 0)
                begin
                    $display("Writeback at %0t with no operation outstanding", $time);
                    error_count++;
                end
                else
                begin
                    e = exp_q.pop_front();
                    compare_value("latency edge", edge_count, e.due_edge, e.test_n);
                    if (e.check_data)
                    begin
                        compare_value("wb_data", wb_data, e.data, e.test_n);
                        compare_value("wb_xcpt_overflow", wb_xcpt_overflow, e.ovf, e.test_n);
                    end
                    compare_value("wb_xcpt_fetch", wb_xcpt_fetch, e.fetch, e.test_n);
                    compare_value("wb_xcpt_illegal", wb_xcpt_illegal, e.illegal, e.test_n);
                    compare_value("wb_rd_addr", wb_rd_addr, e.rd_addr, e.test_n);
                    compare_value("wb_instr_id", wb_instr_id, e.instr_id, e.test_n);
                    compare_value("wb_pc", wb_pc, e.pc, e.test_n);
                    finish_test(e.test_n, "done");
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main flow

    initial
    begin : main_flow
        int fd;
        int n_fields;
        int test_n;
        int wait_n;
        rst_n = 1'b0;
        flush = 1'b0;
        req_valid = 1'b0;
        req_instr_id = '0;
        req_pc = '0;
        req_rd_addr = '0;
        req_ra_data = '0;
        req_rb_data = '0;
        req_ticket_src1 = '0;
        req_ticket_src2 = '0;
        req_blocks_src1 = 1'b0;
        req_blocks_src2 = 1'b0;
        req_xcpt_fetch = 1'b0;
        req_xcpt_illegal = 1'b0;
        rob_hit1_en = 1'b0;
        rob_hit2_en = 1'b0;
        rob_tkt1 = '0;
        rob_tkt2 = '0;
        rob_src1_data = '0;
        rob_src2_data = '0;
        test_n = 0;
        for (int i = 0; i < MAX_TESTS; i++)
            test_errs[i] = 0;
        repeat (2) @(negedge clock);
        compare_value("wb_valid after reset", wb_valid, 1'b0, -1);
        compare_value("stall_decode after reset", stall_decode, 1'b0, -1);
        rst_n = 1'b1;

        fd = $fopen("verification/mul_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open verification/mul_stimulus.txt");
            run_aborted = 1'b1;
        end
        else
        begin
            // Comment and blank lines do not parse to a full set of fields
            while (!run_aborted && $fgets(line_buf, fd) != 0)
            begin
                n_fields = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   f_ra, f_rb, f_blk1, f_blk2, f_tkt1, f_tkt2, f_dly1,
                                   f_dly2, f_robd1, f_robd2, f_fetch, f_ill, f_flush, f_gap);
                if (n_fields == 14)
                begin
                    if (test_n >= MAX_TESTS)
                    begin
                        $display("Stimulus file holds more than %0d requests", MAX_TESTS);
                        run_aborted = 1'b1;
                    end
                    else
                    begin
                        run_request(test_n);
                        if (!run_aborted)
                            idle_cycles(f_gap, f_flush[0]);
                        test_n++;
                    end
                end
            end
            $fclose(fd);
        end

        // Let the pipeline drain
        @(negedge clock);
        flush = 1'b0;
        req_valid = 1'b0;
        rob_hit1_en = 1'b0;
        rob_hit2_en = 1'b0;
        wait_n = 0;
        while (!run_aborted && exp_q.size() != 0)
        begin
            @(negedge clock);
            wait_n++;
            if (wait_n > DRAIN_LIMIT)
            begin
                $display("Timeout: %0d results never reached writeback", exp_q.size());
                run_aborted = 1'b1;
            end
        end
        repeat (4) @(negedge clock);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 pass_count + fail_count, pass_count, fail_count, error_count);
        if (error_count == 0 && !run_aborted && test_n > 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

//--- src/mul_top.sv
`timescale 1ns/1ps

module mul_top import mul_pkg::*;
#(
    parameter int MUL_STAGES = 3
)
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      flush,

    // Decode request
    input  logic      req_valid,
    input  rob_id_t   req_instr_id,
    input  pc_t       req_pc,
    input  reg_addr_t req_rd_addr,
    input  data_t     req_ra_data,
    input  data_t     req_rb_data,
    input  rob_id_t   req_ticket_src1,
    input  rob_id_t   req_ticket_src2,
    input  logic      req_blocks_src1,
    input  logic      req_blocks_src2,
    input  logic      req_xcpt_fetch,
    input  logic      req_xcpt_illegal,
    output logic      stall_decode,

    // Reorder buffer
    output rob_id_t   rob_src1_id,
    output rob_id_t   rob_src2_id,
    input  logic      rob_src1_hit,
    input  logic      rob_src2_hit,
    input  data_t     rob_src1_data,
    input  data_t     rob_src2_data,

    // Writeback
    output logic      wb_valid,
    output rob_id_t   wb_instr_id,
    output pc_t       wb_pc,
    output reg_addr_t wb_rd_addr,
    output data_t     wb_data,
    output logic      wb_xcpt_fetch,
    output logic      wb_xcpt_illegal,
    output logic      wb_xcpt_overflow
);

    mul_issue_if issue_bus ();

    operand_gather i_gather (
        .clock            (clock),
        .rst_n            (rst_n),
        .flush            (flush),
        .req_valid        (req_valid),
        .req_instr_id     (req_instr_id),
        .req_pc           (req_pc),
        .req_rd_addr      (req_rd_addr),
        .req_ra_data      (req_ra_data),
        .req_rb_data      (req_rb_data),
        .req_ticket_src1  (req_ticket_src1),
        .req_ticket_src2  (req_ticket_src2),
        .req_blocks_src1  (req_blocks_src1),
        .req_blocks_src2  (req_blocks_src2),
        .req_xcpt_fetch   (req_xcpt_fetch),
        .req_xcpt_illegal (req_xcpt_illegal),
        .stall_decode     (stall_decode),
        .rob_src1_id      (rob_src1_id),
        .rob_src2_id      (rob_src2_id),
        .rob_src1_hit     (rob_src1_hit),
        .rob_src2_hit     (rob_src2_hit),
        .rob_src1_data    (rob_src1_data),
        .rob_src2_data    (rob_src2_data),
        .issue            (issue_bus.gather)
    );

    mul_pipeline #(
        .MUL_STAGES (MUL_STAGES)
    ) i_pipe (
        .clock            (clock),
        .rst_n            (rst_n),
        .flush            (flush),
        .issue            (issue_bus.pipe),
        .wb_valid         (wb_valid),
        .wb_instr_id      (wb_instr_id),
        .wb_pc            (wb_pc),
        .wb_rd_addr       (wb_rd_addr),
        .wb_data          (wb_data),
        .wb_xcpt_fetch    (wb_xcpt_fetch),
        .wb_xcpt_illegal  (wb_xcpt_illegal),
        .wb_xcpt_overflow (wb_xcpt_overflow)
    );

endmodule

//--- src/mul_pipeline.sv
`timescale 1ns/1ps

module mul_pipeline import mul_pkg::*;
#(
    parameter int MUL_STAGES = 3
)
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      flush,

    mul_issue_if.pipe issue,

    // Writeback request
    output logic      wb_valid,
    output rob_id_t   wb_instr_id,
    output pc_t       wb_pc,
    output reg_addr_t wb_rd_addr,
    output data_t     wb_data,
    output logic      wb_xcpt_fetch,
    output logic      wb_xcpt_illegal,
    output logic      wb_xcpt_overflow
);

    product_t  product;
    logic      overflow;

    // Stage registers
    logic      stg_valid    [MUL_STAGES];
    data_t     stg_data     [MUL_STAGES];
    logic      stg_ovf      [MUL_STAGES];
    logic      stg_fetch    [MUL_STAGES];
    logic      stg_illegal  [MUL_STAGES];
    reg_addr_t stg_rd_addr  [MUL_STAGES];
    rob_id_t   stg_instr_id [MUL_STAGES];
    pc_t       stg_pc       [MUL_STAGES];

    logic      wb_valid_q;

    // Unsigned product at stage 0
    assign product  = product_t'(issue.ra) * product_t'(issue.rb);
    assign overflow = (product[2*DATA_W-1:DATA_W] != '0);

    always_ff @(posedge clock)
    begin
        if (!rst_n || flush)
        begin
            for (int i = 0; i < MUL_STAGES; i++)
            begin
                stg_valid[i] <= 1'b0;
            end
            wb_valid_q <= 1'b0;
        end
        else
        begin
            stg_valid[0] <= issue.issue_valid;
            for (int i = 1; i < MUL_STAGES; i++)
            begin
                stg_valid[i] <= stg_valid[i-1];
            end
            wb_valid_q <= stg_valid[MUL_STAGES-1];
        end
    end

    // Payload just follows the valid bits
    always_ff @(posedge clock)
    begin
        stg_data[0]     <= product[DATA_W-1:0];
        stg_ovf[0]      <= overflow;
        stg_fetch[0]    <= issue.xcpt_fetch;
        stg_illegal[0]  <= issue.xcpt_illegal;
        stg_rd_addr[0]  <= issue.rd_addr;
        stg_instr_id[0] <= issue.instr_id;
        stg_pc[0]       <= issue.pc;
        for (int i = 1; i < MUL_STAGES; i++)
        begin
            stg_data[i]     <= stg_data[i-1];
            stg_ovf[i]      <= stg_ovf[i-1];
            stg_fetch[i]    <= stg_fetch[i-1];
            stg_illegal[i]  <= stg_illegal[i-1];
            stg_rd_addr[i]  <= stg_rd_addr[i-1];
            stg_instr_id[i] <= stg_instr_id[i-1];
            stg_pc[i]       <= stg_pc[i-1];
        end
        wb_data          <= stg_data[MUL_STAGES-1];
        wb_xcpt_overflow <= stg_ovf[MUL_STAGES-1];
        wb_xcpt_fetch    <= stg_fetch[MUL_STAGES-1];
        wb_xcpt_illegal  <= stg_illegal[MUL_STAGES-1];
        wb_rd_addr       <= stg_rd_addr[MUL_STAGES-1];
        wb_instr_id      <= stg_instr_id[MUL_STAGES-1];
        wb_pc            <= stg_pc[MUL_STAGES-1];
    end

    // Flushed ops must not reach writeback in the flush cycle either
    assign wb_valid = wb_valid_q & ~flush;

    // Nothing reaches writeback until a new op has passed every stage after a flush
    no_wb_after_flush: assert property (
        @(posedge clock) disable iff (!rst_n)
        flush |=> (!wb_valid) [*MUL_STAGES]
    );

endmodule

//--- src/operand_gather.sv
`timescale 1ns/1ps

module operand_gather import mul_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  logic        flush,

    // Request from decode
    input  logic        req_valid,
    input  rob_id_t     req_instr_id,
    input  pc_t         req_pc,
    input  reg_addr_t   req_rd_addr,
    input  data_t       req_ra_data,
    input  data_t       req_rb_data,
    input  rob_id_t     req_ticket_src1,
    input  rob_id_t     req_ticket_src2,
    input  logic        req_blocks_src1,
    input  logic        req_blocks_src2,
    input  logic        req_xcpt_fetch,
    input  logic        req_xcpt_illegal,

    output logic        stall_decode,

    // RoB lookup
    output rob_id_t     rob_src1_id,
    output rob_id_t     rob_src2_id,
    input  logic        rob_src1_hit,
    input  logic        rob_src2_hit,
    input  data_t       rob_src1_data,
    input  data_t       rob_src2_data,

    mul_issue_if.gather issue
);

    // Hits seen in earlier cycles of the current request
    logic  src1_found;
    logic  src2_found;
    data_t src1_capt;
    data_t src2_capt;

    logic  has_xcpt;
    logic  src1_waiting;
    logic  src2_waiting;
    logic  accept;

    ////////////////////////////////////////////////////////////////////////////
    // RoB lookup and stall

    assign rob_src1_id = req_ticket_src1;
    assign rob_src2_id = req_ticket_src2;

    // Excepting requests go straight through and never wait on the RoB
    assign has_xcpt = req_xcpt_fetch | req_xcpt_illegal;

    assign src1_waiting = req_blocks_src1 & ~src1_found & ~rob_src1_hit;
    assign src2_waiting = req_blocks_src2 & ~src2_found & ~rob_src2_hit;

    assign stall_decode = req_valid & ~flush & ~has_xcpt & (src1_waiting | src2_waiting);

    assign accept = req_valid & ~flush & ~stall_decode;

    // Hits may be single-cycle pulses, so keep them until the request leaves
    always_ff @(posedge clock)
    begin
        if (!rst_n || flush || accept)
        begin
            src1_found <= 1'b0;
            src2_found <= 1'b0;
            src1_capt  <= '0;
            src2_capt  <= '0;
        end
        else if (stall_decode)
        begin
            if (rob_src1_hit && !src1_found)
            begin
                src1_found <= 1'b1;
                src1_capt  <= rob_src1_data;
            end
            if (rob_src2_hit && !src2_found)
            begin
                src2_found <= 1'b1;
                src2_capt  <= rob_src2_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Issue to pipeline

    assign issue.issue_valid = accept;

    // Live hit first, then captured value, then the value decode gave us
    assign issue.ra = rob_src1_hit    ? rob_src1_data :
                      req_blocks_src1 ? src1_capt     :
                                        req_ra_data;
    assign issue.rb = rob_src2_hit    ? rob_src2_data :
                      req_blocks_src2 ? src2_capt     :
                                        req_rb_data;

    assign issue.rd_addr      = req_rd_addr;
    assign issue.instr_id     = req_instr_id;
    assign issue.pc           = req_pc;
    assign issue.xcpt_fetch   = req_xcpt_fetch;
    assign issue.xcpt_illegal = req_xcpt_illegal;

    // Decode keeps a stalled request and its tickets in place for the next cycle
    stall_holds_req: assert property (
        @(posedge clock) disable iff (!rst_n)
        stall_decode |=> req_valid && $stable(req_ticket_src1) && $stable(req_ticket_src2)
    );

endmodule

//--- src/mul_issue_if.sv
`timescale 1ns/1ps

// Accepted operation from operand gathering into the multiply pipeline
interface mul_issue_if import mul_pkg::*;
();

    logic      issue_valid;
    data_t     ra;
    data_t     rb;
    reg_addr_t rd_addr;
    rob_id_t   instr_id;
    pc_t       pc;
    logic      xcpt_fetch;
    logic      xcpt_illegal;

    // Gather side drives everything, no ready since the pipeline never stalls
    modport gather (
        output issue_valid, ra, rb, rd_addr, instr_id, pc,
        output xcpt_fetch, xcpt_illegal
    );

    modport pipe (
        input issue_valid, ra, rb, rd_addr, instr_id, pc,
        input xcpt_fetch, xcpt_illegal
    );

endinterface

//--- src/mul_pkg.sv
package mul_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths

    // Register value width
    localparam int DATA_W = 32;

    // RoB ticket and instruction id
    localparam int ROB_ID_W = 6;

    localparam int PC_W = 32;

    // Architectural register index
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Vector types

    // Operand or result
    typedef logic [DATA_W-1:0] data_t;

    // Full unsigned product, high half drives overflow
    typedef logic [2*DATA_W-1:0] product_t;

    typedef logic [ROB_ID_W-1:0] rob_id_t;

    typedef logic [PC_W-1:0] pc_t;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

endpackage
